// ==== flist.f ====
verilog/dmem_map_pkg.sv
verilog/dmem_ctrl_pkg.sv
verilog/data_mem.sv
verilog/dmem_ctrl.sv
verilog/dmem_csr.sv
verilog/dmem_rdata_mux.sv
verilog/dmem_top.sv
bench/dmem_tb.sv

// ==== Makefile ====
# verilator build and run of the data-memory testbench

TOP = dmem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

# pass or fail is taken from the log, not from the exit code
sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/dmem_tb.sv ====
`timescale 1ns/100ps

module dmem_tb
   import dmem_map_pkg::*;
();

   localparam int MAX_WAIT   = 20;  // cycles until a missing response counts as a hang
   localparam int REGION_RAM = 0;
   localparam int REGION_CSR = 1;
   localparam int REGION_ERR = 2;

   typedef struct {
      logic      wr;
      bus_addr_t adr;
      byte_sel_t sel;
      word_t     dat;
      logic      exp_err;
      word_t     exp_dat;  // dat_o expected on a read ack
   } step_t;

   logic      clk;
   logic      reset;
   logic      cyc;
   logic      stb;
   logic      we;
   bus_addr_t adr;
   word_t     dat_w;
   byte_sel_t sel;
   logic      ack;
   logic      err;
   word_t     dat_r;

   logic [7:0]  model_ram [RAM_BYTES];  // byte image of the ram
   int unsigned model_wr;
   int unsigned model_rd;
   int unsigned model_err;
   word_t       last_dat;               // word dat_o should hold between reads
   step_t       steps [$];
   int          seed = 91636;

   dmem_top DUT (
      .clk_i   (clk),
      .reset_i (reset),
      .cyc_i   (cyc),
      .stb_i   (stb),
      .we_i    (we),
      .adr_i   (adr),
      .dat_i   (dat_w),
      .sel_i   (sel),
      .ack_o   (ack),
      .err_o   (err),
      .dat_o   (dat_r)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // decode straight from the memory map
   function automatic int region_of(bus_addr_t a, byte_sel_t s);
      if (s == 4'h0) return REGION_ERR;     // empty select
      if (a < 16'h2000) return REGION_RAM;
      if (a >= 16'h8000 && a < 16'h8010) return REGION_CSR;
      return REGION_ERR;
   endfunction

   function automatic word_t model_word(bus_addr_t a, byte_sel_t s);
      word_t w;
      for (int b = 0; b < 4; b++) begin
         w[8*b +: 8] = s[b] ? model_ram[{a[12:2], 2'(b)}] : 8'h00;  // unselected lanes read 0
      end
      return w;
   endfunction

   task automatic update_model(input logic wr, input bus_addr_t a, input byte_sel_t s,
                               input word_t d);
      int region;
      region = region_of(a, s);
      if (region == REGION_ERR) begin
         model_err++;
      end else if (region == REGION_RAM && wr) begin
         model_wr++;
         for (int b = 0; b < 4; b++) begin
            if (s[b]) model_ram[{a[12:2], 2'(b)}] = d[8*b +: 8];
         end
      end else if (region == REGION_RAM) begin
         model_rd++;
      end else if (wr && a[3:2] == CSR_WR_COUNT) begin
         model_wr = 0;  // counter write clears it
      end else if (wr && a[3:2] == CSR_RD_COUNT) begin
         model_rd = 0;
      end else if (wr && a[3:2] == CSR_ERR_COUNT) begin
         model_err = 0;
      end
   endtask

   // one classic cycle up to the dead cycle that follows the response
   task automatic bus_access(input logic wr, input bus_addr_t a, input byte_sel_t s,
                             input word_t d, output logic got_ack, output logic got_err,
                             output word_t rdata, output int waited);
      waited = 0;
      cyc    = 1'b1;
      stb    = 1'b1;
      we     = wr;
      adr    = a;
      sel    = s;
      dat_w  = d;
      do begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > MAX_WAIT) begin
            $display("slave never responded to the access at address %04h", a);
            abort_run();
         end
      end while (!ack && !err);
      got_ack = ack;
      got_err = err;
      rdata   = dat_r;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      @(posedge clk);  // DONE cycle
      #1;
      check("response after its single cycle", {30'd0, ack, err}, 32'd0);
   endtask

   task automatic do_access(input string what, input logic wr, input bus_addr_t a,
                            input byte_sel_t s, input word_t d, input logic exp_err,
                            input word_t exp_dat);
      logic  got_ack;
      logic  got_err;
      word_t rdata;
      word_t exp_out;
      int    waited;
      bus_access(wr, a, s, d, got_ack, got_err, rdata, waited);
      if (wr) begin
         exp_out = last_dat;  // writes leave dat_o alone
      end else if (exp_err) begin
         exp_out = '0;        // error reads load zero
      end else begin
         exp_out = exp_dat;
      end
      check({what, " latency"}, word_t'(waited), 32'd1);  // one edge after sampling
      check({what, " ack"}, 32'(got_ack), 32'(!exp_err));
      check({what, " err"}, 32'(got_err), 32'(exp_err));
      check({what, " data"}, rdata, exp_out);
      last_dat = exp_out;
      update_model(wr, a, s, d);
   endtask

   // strobe left high so accesses complete on every second edge
   task automatic held_strobe(input bus_addr_t a, input word_t exp_dat, input int edges);
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      sel = 4'hF;
      for (int i = 0; i < edges; i++) begin
         @(posedge clk);
         #1;
         check("held strobe ack", 32'(ack), 32'(i % 2 == 0));
         check("held strobe err", 32'(err), 32'd0);
         if (ack) begin
            check("held strobe data", dat_r, exp_dat);
            model_rd++;
            last_dat = exp_dat;
         end
      end
      cyc = 1'b0;
      stb = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic add_step(input logic wr, input bus_addr_t a, input byte_sel_t s,
                           input word_t d, input logic e, input word_t x);
      steps.push_back('{wr, a, s, d, e, x});
   endtask

   initial begin
      bus_addr_t a;
      byte_sel_t s;
      word_t     d;
      int        r;
      logic      wr;
      reset = 1'b1;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      sel   = '0;
      model_wr  = 0;
      model_rd  = 0;
      model_err = 0;
      last_dat  = '0;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      check("ack after reset", 32'(ack), 32'd0);
      check("err after reset", 32'(err), 32'd0);
      check("dat_o after reset", dat_r, 32'd0);

      add_step(1'b1, 16'h0000, 4'hF, 32'h0102_0304, 1'b0, '0);       // full words
      add_step(1'b1, 16'h0010, 4'hF, 32'h1122_3344, 1'b0, '0);
      add_step(1'b0, 16'h0010, 4'hF, '0, 1'b0, 32'h1122_3344);
      add_step(1'b1, 16'h0010, 4'h2, 32'hAABB_CCDD, 1'b0, '0);       // one lane
      add_step(1'b0, 16'h0010, 4'hF, '0, 1'b0, 32'h1122_CC44);
      add_step(1'b1, 16'h0010, 4'h9, 32'h5566_7788, 1'b0, '0);       // outer lanes
      add_step(1'b0, 16'h0010, 4'hF, '0, 1'b0, 32'h5522_CC88);
      add_step(1'b0, 16'h0010, 4'h6, '0, 1'b0, 32'h0022_CC00);
      add_step(1'b0, 16'h0010, 4'h1, '0, 1'b0, 32'h0000_0088);
      add_step(1'b1, 16'h4000, 4'hF, 32'hDEAD_BEEF, 1'b1, '0);       // aliases word 0 if decoded wrong
      add_step(1'b1, 16'h0010, 4'h0, 32'hDEAD_BEEF, 1'b1, '0);       // empty select
      add_step(1'b0, 16'h2000, 4'hF, '0, 1'b1, '0);                  // just past the ram
      add_step(1'b0, 16'h8010, 4'hF, '0, 1'b1, '0);                  // just past the registers
      add_step(1'b0, 16'h0000, 4'hF, '0, 1'b0, 32'h0102_0304);
      add_step(1'b0, 16'h0010, 4'hF, '0, 1'b0, 32'h5522_CC88);
      add_step(1'b1, 16'h8000, 4'hF, 32'hCAFE_F00D, 1'b0, '0);       // scratch
      add_step(1'b1, 16'h8000, 4'h4, 32'h0077_0000, 1'b0, '0);
      add_step(1'b0, 16'h8000, 4'hF, '0, 1'b0, 32'hCA77_F00D);
      add_step(1'b0, 16'h8000, 4'h3, '0, 1'b0, 32'h0000_F00D);
      add_step(1'b0, 16'h0000, 4'hF, '0, 1'b0, 32'h0102_0304);       // ram behind scratch intact
      foreach (steps[i]) begin
         do_access($sformatf("step %0d", i), steps[i].wr, steps[i].adr, steps[i].sel,
                   steps[i].dat, steps[i].exp_err, steps[i].exp_dat);
      end

      held_strobe(16'h0010, 32'h5522_CC88, 6);

      // 64-word window with a pattern built from the whole address
      for (int i = 0; i < 64; i++) begin
         a = 16'h0100 + 16'(4 * i);
         do_access("prefill", 1'b1, a, 4'hF, {~a, a}, 1'b0, '0);
      end
      for (int i = 0; i < 80; i++) begin
         r  = $random(seed);
         d  = $random(seed);
         a  = {8'h01, r[7:2], 2'b00};
         s  = (r[11:8] == 4'h0) ? 4'hF : r[11:8];
         wr = r[13];
         if (r[1:0] == 2'd2) begin
            if (r[12]) a = {2'b01, r[27:14]};  // unmapped hole
            else s = 4'h0;
         end
         do_access($sformatf("random %0d", i), wr, a, s, d,
                   region_of(a, s) == REGION_ERR, model_word(a, s));
      end

      do_access("write count", 1'b0, 16'h8004, 4'hF, '0, 1'b0, model_wr);
      do_access("read count", 1'b0, 16'h8008, 4'hF, '0, 1'b0, model_rd);
      do_access("error count", 1'b0, 16'h800C, 4'hF, '0, 1'b0, model_err);
      do_access("clear write count", 1'b1, 16'h8004, 4'hF, 32'hFFFF_FFFF, 1'b0, '0);
      do_access("cleared write count", 1'b0, 16'h8004, 4'hF, '0, 1'b0, 32'd0);
      do_access("clear read count", 1'b1, 16'h8008, 4'h2, 32'h0000_0100, 1'b0, '0);
      do_access("cleared read count", 1'b0, 16'h8008, 4'hF, '0, 1'b0, 32'd0);
      do_access("clear error count", 1'b1, 16'h800C, 4'h1, 32'h0000_0001, 1'b0, '0);
      do_access("cleared error count", 1'b0, 16'h800C, 4'hF, '0, 1'b0, 32'd0);

      $display("all tests passed");
      $finish;
   end

endmodule

// ==== verilog/dmem_top.sv ====
`timescale 1ns/100ps

// data-memory subsystem, one wishbone classic slave
//   0x0000..0x1fff  data ram
//   0x8000..0x800f  control and status registers
// anything else, or an empty select, ends with err

module dmem_top
   import dmem_map_pkg::*, dmem_ctrl_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      cyc_i,
   input  logic      stb_i,
   input  logic      we_i,
   input  bus_addr_t adr_i,
   input  word_t     dat_i,
   input  byte_sel_t sel_i,
   output logic      ack_o,
   output logic      err_o,
   output word_t     dat_o
);

   logic       ram_we;
   logic       csr_we;
   logic       ram_wr_evt;
   logic       ram_rd_evt;
   logic       err_evt;
   logic       load_en;
   resp_kind_t kind;
   word_t      ram_rdata;
   word_t      csr_rdata;
   ram_addr_t  ram_addr;
   csr_idx_t   csr_idx;

   assign ram_addr = adr_i[RAM_AW-1:0];  // byte address inside the ram
   assign csr_idx  = adr_i[3:2];         // word slot inside the csr block

   dmem_ctrl u_ctrl (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cyc_i        (cyc_i),
      .stb_i        (stb_i),
      .we_i         (we_i),
      .adr_i        (adr_i),
      .sel_i        (sel_i),
      .ack_o        (ack_o),
      .err_o        (err_o),
      .ram_we_o     (ram_we),
      .csr_we_o     (csr_we),
      .ram_wr_evt_o (ram_wr_evt),
      .ram_rd_evt_o (ram_rd_evt),
      .err_evt_o    (err_evt),
      .load_en_o    (load_en),
      .kind_o       (kind)
   );

   data_mem u_ram (
      .clk_i    (clk_i),
      .write_i  (ram_we),
      .be_sel_i (sel_i),      // lane gating happens inside the ram
      .addr_i   (ram_addr),
      .data_i   (dat_i),
      .data_o   (ram_rdata)
   );

   dmem_csr u_csr (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .write_i      (csr_we),
      .idx_i        (csr_idx),
      .sel_i        (sel_i),
      .data_i       (dat_i),
      .ram_wr_evt_i (ram_wr_evt),
      .ram_rd_evt_i (ram_rd_evt),
      .err_evt_i    (err_evt),
      .data_o       (csr_rdata)
   );

   dmem_rdata_mux u_rdata (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .load_en_i  (load_en),
      .kind_i     (kind),
      .sel_i      (sel_i),
      .ram_data_i (ram_rdata),
      .csr_data_i (csr_rdata),
      .data_o     (dat_o)
   );

endmodule

// ==== verilog/dmem_rdata_mux.sv ====
`timescale 1ns/100ps

// read data path
// picks ram or csr word, zeroes unselected lanes and holds it on dat_o
// until the next read

module dmem_rdata_mux
   import dmem_map_pkg::*, dmem_ctrl_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       load_en_i,   // accepting cycle of a read
   input  resp_kind_t kind_i,
   input  byte_sel_t  sel_i,
   input  word_t      ram_data_i,
   input  word_t      csr_data_i,
   output word_t      data_o
);

   word_t pick;
   word_t masked;

   always_comb begin
      case (kind_i)
         RESP_RAM: pick = ram_data_i;
         RESP_CSR: pick = csr_data_i;
         default:  pick = '0;       // error reads return zero
      endcase
      for (int b = 0; b < SEL_W; b++) begin
         masked[8*b +: 8] = sel_i[b] ? pick[8*b +: 8] : 8'h00;
      end
   end

   // output word, updated together with the ack register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         data_o <= '0;
      end else if (load_en_i) begin
         data_o <= masked;
      end
   end

endmodule

// ==== verilog/dmem_csr.sv ====
`timescale 1ns/100ps

// control and status registers
//   0  scratch, byte-writable
//   1  ram write count
//   2  ram read count
//   3  error response count
// a write to a counter clears it, sel is ignored there

module dmem_csr
   import dmem_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      write_i,       // register write strobe
   input  csr_idx_t  idx_i,
   input  byte_sel_t sel_i,
   input  word_t     data_i,
   input  logic      ram_wr_evt_i,
   input  logic      ram_rd_evt_i,
   input  logic      err_evt_i,
   output word_t     data_o
);

   word_t scratch_q;
   word_t cnt_q [N_COUNTERS];           // wr, rd, err
   logic [N_COUNTERS-1:0] cnt_evt;

   assign cnt_evt = {err_evt_i, ram_rd_evt_i, ram_wr_evt_i};

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         scratch_q <= '0;
         for (int c = 0; c < N_COUNTERS; c++) begin
            cnt_q[c] <= '0;
         end
      end else begin
         // scratch, per byte lane
         if (write_i && idx_i == CSR_SCRATCH) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (sel_i[b]) begin
                  scratch_q[8*b +: 8] <= data_i[8*b +: 8];
               end
            end
         end
         // counters, clear wins over the event
         for (int c = 0; c < N_COUNTERS; c++) begin
            if (write_i && idx_i == csr_idx_t'(CSR_WR_COUNT + c)) begin
               cnt_q[c] <= '0;
            end else if (cnt_evt[c]) begin
               cnt_q[c] <= cnt_q[c] + 1'b1;  // wraps at 2^32
            end
         end
      end
   end

   // combinational read, decoded on the index only
   always_comb begin
      case (idx_i)
         CSR_SCRATCH:   data_o = scratch_q;
         CSR_WR_COUNT:  data_o = cnt_q[0];
         CSR_RD_COUNT:  data_o = cnt_q[1];
         CSR_ERR_COUNT: data_o = cnt_q[2];
         default:       data_o = '0;
      endcase
   end

endmodule

// ==== verilog/dmem_ctrl.sv ====
`timescale 1ns/100ps

// wishbone classic slave control
// decodes the address, runs the access fsm, issues one-cycle strobes
// to the datapath and registers ack / err

module dmem_ctrl
   import dmem_map_pkg::*, dmem_ctrl_pkg::*;
(
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       cyc_i,
   input  logic       stb_i,
   input  logic       we_i,
   input  bus_addr_t  adr_i,
   input  byte_sel_t  sel_i,
   output logic       ack_o,
   output logic       err_o,
   output logic       ram_we_o,      // ram write, this cycle
   output logic       csr_we_o,      // register write, this cycle
   output logic       ram_wr_evt_o,  // count a ram write
   output logic       ram_rd_evt_o,  // count a ram read
   output logic       err_evt_o,     // count an error response
   output logic       load_en_o,     // load read word into dat_o
   output resp_kind_t kind_o
);

   bus_state_t state_q, state_d;
   bus_state_t phase;       // phase of the current cycle

   logic ram_hit, csr_hit;
   logic sel_ok;
   logic bad;               // ends in err
   logic accept;

   // address decode, both regions aligned to their size
   assign ram_hit = adr_i[BUS_AW-1:RAM_AW] == RAM_BASE[BUS_AW-1:RAM_AW];
   assign csr_hit = adr_i[BUS_AW-1:CSR_AW] == CSR_BASE[BUS_AW-1:CSR_AW];
   assign sel_ok  = |sel_i;                 // empty select is an error
   assign bad     = !sel_ok || !(ram_hit || csr_hit);

   // a request seen in IDLE makes this the accepting cycle
   always_comb begin
      phase = state_q;
      if (state_q == IDLE && cyc_i && stb_i) begin
         phase = RESP;
      end
   end

   assign accept = (phase == RESP);

   always_comb begin
      case (phase)
         RESP:    state_d = DONE;   // response goes out next cycle
         DONE:    state_d = IDLE;   // master still holds the old strobe here
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // datapath strobes, only in the accepting cycle
   assign ram_we_o     = accept && we_i && ram_hit && sel_ok;
   assign csr_we_o     = accept && we_i && csr_hit && sel_ok;
   assign ram_wr_evt_o = ram_we_o;
   assign ram_rd_evt_o = accept && !we_i && ram_hit && sel_ok;
   assign err_evt_o    = accept && bad;
   assign load_en_o    = accept && !we_i;  // reads only, err reads load zero

   always_comb begin
      if (bad) begin
         kind_o = RESP_ERR;
      end else if (csr_hit) begin
         kind_o = RESP_CSR;
      end else begin
         kind_o = RESP_RAM;
      end
   end

   // response registered at the accepting edge, high for exactly one cycle
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end else begin
         ack_o <= accept && !bad;
         err_o <= accept && bad;
      end
   end

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/100ps

// 8 KB byte-addressed data ram
// four byte lanes per word, word read is asynchronous
// contents undefined until written

module data_mem
   import dmem_map_pkg::*;
(
   input  logic      clk_i,
   input  logic      write_i,   // write strobe from the bus fsm
   input  byte_sel_t be_sel_i,  // lane enables
   input  ram_addr_t addr_i,    // byte address, low bits ignored
   input  word_t     data_i,
   output word_t     data_o
);

   logic [7:0] mem [RAM_BYTES];  // byte array, no reset

   word_t rd_word;

   // async read of the whole aligned word
   always_comb begin
      for (int b = 0; b < SEL_W; b++) begin
         rd_word[8*b +: 8] = mem[{addr_i[RAM_AW-1:2], 2'(b)}];
      end
   end

   assign data_o = rd_word;

   // byte-lane write, lanes with clear select keep their old value
   always_ff @(posedge clk_i) begin
      if (write_i) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (be_sel_i[b]) begin
               mem[{addr_i[RAM_AW-1:2], 2'(b)}] <= data_i[8*b +: 8];
            end
         end
      end
   end

   // read-during-write on the same word returns the old bytes until the
   // edge, the fsm never reads and writes in one access anyway

endmodule

// ==== verilog/dmem_ctrl_pkg.sv ====
// control encodings shared by the bus fsm and the datapath

package dmem_ctrl_pkg;

   // phases of one wishbone classic access
   //   IDLE  waiting for cyc and stb
   //   RESP  accepting cycle, strobes out, response registered at its end
   //   DONE  response on the bus, held strobe of the finished access ignored
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RESP = 2'd1,
      DONE = 2'd2
   } bus_state_t;

   // which kind of response the current access ends with
   // the read mux picks its source from this
   typedef enum logic [1:0] {
      RESP_RAM = 2'd0, // ack, data from ram
      RESP_CSR = 2'd1, // ack, data from csr block
      RESP_ERR = 2'd2  // err, no data
   } resp_kind_t;

   // note: RESP_ERR loads a zero word on reads so stale data never
   // shows up behind an error

endpackage

// ==== verilog/dmem_map_pkg.sv ====
// memory map of the data-memory subsystem
// fixed layout, seen from the wishbone side

package dmem_map_pkg;

   localparam int BUS_AW = 16;       // wishbone byte address width
   localparam int RAM_AW = 13;       // 8 KB of ram
   localparam int CSR_AW = 4;        // four 32-bit registers
   localparam int DATA_W = 32;
   localparam int SEL_W  = DATA_W / 8; // one select bit per byte lane

   typedef logic [BUS_AW-1:0] bus_addr_t;
   typedef logic [RAM_AW-1:0] ram_addr_t;
   typedef logic [DATA_W-1:0] word_t;
   typedef logic [SEL_W-1:0]  byte_sel_t;
   typedef logic [1:0]        csr_idx_t;  // adr bits 3:2

   localparam int RAM_BYTES = 8192;

   // region bases, each aligned to its own size
   localparam bus_addr_t RAM_BASE = 16'h0000;
   localparam bus_addr_t CSR_BASE = 16'h8000;

   // register slots in the csr region
   localparam csr_idx_t CSR_SCRATCH   = 2'd0; // free for software
   localparam csr_idx_t CSR_WR_COUNT  = 2'd1; // completed ram writes
   localparam csr_idx_t CSR_RD_COUNT  = 2'd2; // completed ram reads
   localparam csr_idx_t CSR_ERR_COUNT = 2'd3; // error responses

   // counters sit in the three slots above the scratch register,
   // in the order wr, rd, err
   localparam int N_COUNTERS = 3;

endpackage
